// ==== logic/cpuPkg.sv ====
package cpuPkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;

    typedef enum logic [2:0] {
        lda,
        sta,
        adc,
        andOp,
        jmp,
        beq,
        bne,
        nop
    } instrT;

    typedef enum logic [1:0] {
        implied,
        immediate,
        absolute,
        relative
    } addrModeT;

    typedef enum logic [2:0] {
        vecLow,
        vecHigh,
        fetch,
        operand,
        operandHigh,
        dataAccess,
        branchTake
    } cycleStateT;

    localparam int numFlags = 12;

    localparam int flagPcInc         = 0;
    localparam int flagPcLoadLow     = 1;  // Relative branch adds the signed latch byte to the PC
    localparam int flagPcLoadHigh    = 2;  // Loads the data bus as high byte over the latch low byte
    localparam int flagAddrFromPc    = 3;
    localparam int flagAddrFromLatch = 4;
    localparam int flagAddrVector    = 5;
    localparam int flagLatchLow      = 6;
    localparam int flagLatchHigh     = 7;
    localparam int flagLoadA         = 8;
    localparam int flagAluAdc        = 9;
    localparam int flagAluAnd        = 10;
    localparam int flagWrite         = 11;

    typedef logic [numFlags-1:0] ctrlFlagsT;

    localparam addrT resetVectorLow = 16'hFFFC;

    // Standard 6502 encodings of the supported instructions
    localparam byteT opLdaImm = 8'hA9;
    localparam byteT opLdaAbs = 8'hAD;
    localparam byteT opStaAbs = 8'h8D;
    localparam byteT opAdcImm = 8'h69;
    localparam byteT opAndImm = 8'h29;
    localparam byteT opJmpAbs = 8'h4C;
    localparam byteT opBeq    = 8'hF0;
    localparam byteT opBne    = 8'hD0;
    localparam byteT opNop    = 8'hEA;

endpackage

// ==== logic/controlBus.sv ====
`timescale 1ns/100ps

interface controlBus;

    cpuPkg::ctrlFlagsT flags;         // One bit per micro-action of the current cycle
    logic              vectorSelect;  // High byte of the reset vector when set
    logic              zeroFlag;
    logic              carryFlag;

    modport ctrl (
        output flags,
        output vectorSelect,
        input  zeroFlag
    );

    modport data (
        input  flags,
        input  vectorSelect,
        output zeroFlag,
        output carryFlag
    );

endinterface

// ==== logic/instructionLoader.sv ====
`timescale 1ns/100ps

module instructionLoader (
    input  logic         clk,
    input  logic         arstN,
    input  logic         enableFFs,
    input  logic         loadOpcode,
    input  cpuPkg::byteT dataBusInput,
    output cpuPkg::byteT opcode
);

    logic captureOpcode;

    // The fetch cycle only completes when the memory has answered
    assign captureOpcode = loadOpcode & enableFFs;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opcode <= cpuPkg::opNop;  // Keeps the decoder on a known instruction before the first fetch
        end else if (captureOpcode) begin
            opcode <= dataBusInput;
        end
    end

endmodule

// ==== logic/opcodeDecoder.sv ====
`timescale 1ns/100ps

module opcodeDecoder (
    input  cpuPkg::byteT     opcode,
    output cpuPkg::instrT    instr,
    output cpuPkg::addrModeT addrMode
);

    always_comb begin
        instr    = cpuPkg::nop;
        addrMode = cpuPkg::implied;
        case (opcode)
            cpuPkg::opLdaImm: begin
                instr    = cpuPkg::lda;
                addrMode = cpuPkg::immediate;
            end
            cpuPkg::opLdaAbs: begin
                instr    = cpuPkg::lda;
                addrMode = cpuPkg::absolute;
            end
            cpuPkg::opStaAbs: begin
                instr    = cpuPkg::sta;
                addrMode = cpuPkg::absolute;
            end
            cpuPkg::opAdcImm: begin
                instr    = cpuPkg::adc;
                addrMode = cpuPkg::immediate;
            end
            cpuPkg::opAndImm: begin
                instr    = cpuPkg::andOp;
                addrMode = cpuPkg::immediate;
            end
            cpuPkg::opJmpAbs: begin
                instr    = cpuPkg::jmp;
                addrMode = cpuPkg::absolute;
            end
            cpuPkg::opBeq: begin
                instr    = cpuPkg::beq;
                addrMode = cpuPkg::relative;
            end
            cpuPkg::opBne: begin
                instr    = cpuPkg::bne;
                addrMode = cpuPkg::relative;
            end
            cpuPkg::opNop: begin
                instr    = cpuPkg::nop;
                addrMode = cpuPkg::implied;
            end
            default: begin
                instr    = cpuPkg::nop;  // Unsupported opcodes run as a two cycle NOP
                addrMode = cpuPkg::implied;
            end
        endcase
    end

endmodule

// ==== logic/cycleController.sv ====
`timescale 1ns/100ps

module cycleController (
    input  logic             clk,
    input  logic             arstN,
    input  logic             enableFFs,
    input  cpuPkg::instrT    instr,
    input  cpuPkg::addrModeT addrMode,
    output logic             loadOpcode,
    output logic             sync,
    controlBus.ctrl          bus
);

    cpuPkg::cycleStateT state;
    cpuPkg::cycleStateT nextState;
    cpuPkg::ctrlFlagsT  flags;
    logic               vectorSelect;
    logic               branchTaken;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::vecLow;
        end else if (enableFFs) begin
            state <= nextState;
        end
    end

    // BEQ waits on a set zero flag, BNE on a clear one
    assign branchTaken = (instr == cpuPkg::beq) ? bus.zeroFlag : ~bus.zeroFlag;

    always_comb begin
        flags        = '0;
        vectorSelect = 1'b0;
        nextState    = state;
        case (state)
            cpuPkg::vecLow: begin
                flags[cpuPkg::flagAddrVector] = 1'b1;
                flags[cpuPkg::flagLatchLow]   = 1'b1;
                nextState                     = cpuPkg::vecHigh;
            end
            cpuPkg::vecHigh: begin
                vectorSelect                  = 1'b1;
                flags[cpuPkg::flagAddrVector] = 1'b1;
                flags[cpuPkg::flagPcLoadHigh] = 1'b1;
                nextState                     = cpuPkg::fetch;
            end
            cpuPkg::fetch: begin
                flags[cpuPkg::flagAddrFromPc] = 1'b1;
                flags[cpuPkg::flagPcInc]      = 1'b1;
                nextState                     = cpuPkg::operand;
            end
            cpuPkg::operand: begin
                flags[cpuPkg::flagAddrFromPc] = 1'b1;
                nextState                     = cpuPkg::fetch;
                case (addrMode)
                    cpuPkg::immediate: begin
                        flags[cpuPkg::flagPcInc]  = 1'b1;
                        flags[cpuPkg::flagLoadA]  = (instr == cpuPkg::lda);
                        flags[cpuPkg::flagAluAdc] = (instr == cpuPkg::adc);
                        flags[cpuPkg::flagAluAnd] = (instr == cpuPkg::andOp);
                    end
                    cpuPkg::relative: begin
                        flags[cpuPkg::flagPcInc]    = 1'b1;
                        flags[cpuPkg::flagLatchLow] = 1'b1;  // Keeps the offset for the taken cycle
                        if (branchTaken) begin
                            nextState = cpuPkg::branchTake;
                        end
                    end
                    cpuPkg::absolute: begin
                        flags[cpuPkg::flagPcInc]    = 1'b1;
                        flags[cpuPkg::flagLatchLow] = 1'b1;
                        nextState                   = cpuPkg::operandHigh;
                    end
                    default: begin
                        nextState = cpuPkg::fetch;  // NOP only reads the next byte and drops it
                    end
                endcase
            end
            cpuPkg::operandHigh: begin
                flags[cpuPkg::flagAddrFromPc] = 1'b1;
                if (instr == cpuPkg::jmp) begin
                    flags[cpuPkg::flagPcLoadHigh] = 1'b1;
                    nextState                     = cpuPkg::fetch;
                end else begin
                    flags[cpuPkg::flagPcInc]     = 1'b1;
                    flags[cpuPkg::flagLatchHigh] = 1'b1;
                    nextState                    = cpuPkg::dataAccess;
                end
            end
            cpuPkg::dataAccess: begin
                flags[cpuPkg::flagAddrFromLatch] = 1'b1;
                flags[cpuPkg::flagWrite]         = (instr == cpuPkg::sta);
                flags[cpuPkg::flagLoadA]         = (instr == cpuPkg::lda);
                nextState                        = cpuPkg::fetch;
            end
            cpuPkg::branchTake: begin
                flags[cpuPkg::flagAddrFromPc] = 1'b1;
                flags[cpuPkg::flagPcLoadLow]  = 1'b1;
                nextState                     = cpuPkg::fetch;
            end
            default: begin
                nextState = cpuPkg::vecLow;
            end
        endcase
    end

    assign bus.flags        = flags;
    assign bus.vectorSelect = vectorSelect;
    assign loadOpcode       = (state == cpuPkg::fetch);
    assign sync             = (state == cpuPkg::fetch);

endmodule

// ==== logic/internalDataflow.sv ====
`timescale 1ns/100ps

module internalDataflow (
    input  logic         clk,
    input  logic         arstN,
    input  logic         enableFFs,
    input  cpuPkg::byteT dataBusInput,
    output cpuPkg::byteT dataBusOutput,
    output cpuPkg::byteT addressBusHigh,
    output cpuPkg::byteT addressBusLow,
    controlBus.data      bus
);

    cpuPkg::ctrlFlagsT flags;
    cpuPkg::addrT      pc;
    cpuPkg::addrT      operandLatch;
    cpuPkg::addrT      vectorAddr;
    cpuPkg::addrT      address;
    cpuPkg::addrT      branchOffset;
    cpuPkg::byteT      accumulator;
    cpuPkg::byteT      aluResult;
    logic [8:0]        aluSum;
    logic              accWrite;

    assign flags = bus.flags;

    assign vectorAddr = cpuPkg::resetVectorLow | {15'b0, bus.vectorSelect};

    // The controller raises exactly one address source per cycle
    assign address = ({16{flags[cpuPkg::flagAddrFromPc]}}    & pc)
                   | ({16{flags[cpuPkg::flagAddrFromLatch]}} & operandLatch)
                   | ({16{flags[cpuPkg::flagAddrVector]}}    & vectorAddr);

    assign addressBusHigh = address[15:8];
    assign addressBusLow  = address[7:0];
    assign dataBusOutput  = accumulator;

    assign branchOffset = {{8{operandLatch[7]}}, operandLatch[7:0]};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (enableFFs) begin
            if (flags[cpuPkg::flagPcLoadHigh]) begin
                pc <= {dataBusInput, operandLatch[7:0]};
            end else if (flags[cpuPkg::flagPcLoadLow]) begin
                pc <= pc + branchOffset;  // PC already points past the offset byte
            end else if (flags[cpuPkg::flagPcInc]) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enableFFs && flags[cpuPkg::flagLatchLow]) begin
            operandLatch[7:0] <= dataBusInput;
        end
        if (enableFFs && flags[cpuPkg::flagLatchHigh]) begin
            operandLatch[15:8] <= dataBusInput;
        end
    end

    assign aluSum = {1'b0, accumulator} + {1'b0, dataBusInput} + {8'b0, bus.carryFlag};

    always_comb begin
        aluResult = dataBusInput;  // Plain load passes the bus through
        if (flags[cpuPkg::flagAluAdc]) begin
            aluResult = aluSum[7:0];
        end else if (flags[cpuPkg::flagAluAnd]) begin
            aluResult = accumulator & dataBusInput;
        end
    end

    assign accWrite = flags[cpuPkg::flagLoadA] | flags[cpuPkg::flagAluAdc]
                    | flags[cpuPkg::flagAluAnd];

    always_ff @(posedge clk) begin
        if (enableFFs && accWrite) begin
            accumulator <= aluResult;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bus.zeroFlag  <= 1'b0;
            bus.carryFlag <= 1'b0;
        end else if (enableFFs) begin
            if (accWrite) begin
                bus.zeroFlag <= (aluResult == 8'h00);
            end
            if (flags[cpuPkg::flagAluAdc]) begin
                bus.carryFlag <= aluSum[8];  // AND and LDA leave carry alone
            end
        end
    end

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore (
    input  logic         clk,
    input  logic         arstN,
    input  logic         ready,
    input  cpuPkg::byteT dataBusInput,
    output cpuPkg::byteT dataBusOutput,
    output cpuPkg::byteT addressBusHigh,
    output cpuPkg::byteT addressBusLow,
    output logic         sync,
    output logic         readNotWrite
);

    cpuPkg::byteT     opcode;
    cpuPkg::instrT    instr;
    cpuPkg::addrModeT addrMode;
    logic             loadOpcode;
    logic             enableFFs;

    controlBus ctrlBus ();

    assign readNotWrite = ~ctrlBus.flags[cpuPkg::flagWrite];
    assign enableFFs    = ready | ~readNotWrite;  // Writes never wait for ready

    instructionLoader instructionLoader (
        .clk          (clk),
        .arstN        (arstN),
        .enableFFs    (enableFFs),
        .loadOpcode   (loadOpcode),
        .dataBusInput (dataBusInput),
        .opcode       (opcode)
    );

    opcodeDecoder opcodeDecoder (
        .opcode   (opcode),
        .instr    (instr),
        .addrMode (addrMode)
    );

    cycleController cycleController (
        .clk        (clk),
        .arstN      (arstN),
        .enableFFs  (enableFFs),
        .instr      (instr),
        .addrMode   (addrMode),
        .loadOpcode (loadOpcode),
        .sync       (sync),
        .bus        (ctrlBus.ctrl)
    );

    internalDataflow internalDataflow (
        .clk            (clk),
        .arstN          (arstN),
        .enableFFs      (enableFFs),
        .dataBusInput   (dataBusInput),
        .dataBusOutput  (dataBusOutput),
        .addressBusHigh (addressBusHigh),
        .addressBusLow  (addressBusLow),
        .bus            (ctrlBus.data)
    );

endmodule

// ==== verif/cpuCore_props.sv ====
`timescale 1ns/100ps

module cpuCoreProps (
    input logic         clk,
    input logic         arstN,
    input logic         ready,
    input logic         sync,
    input logic         readNotWrite,
    input cpuPkg::byteT addressBusHigh,
    input cpuPkg::byteT addressBusLow
);

    // Bus strobes stay idle while reset is held
    resetIdle: assert property (@(posedge clk) !arstN |-> (readNotWrite && !sync))
        else $error("Bus strobes active during reset");

    stallHoldsAddress: assert property (@(posedge clk) disable iff (!arstN)
        (!ready && readNotWrite) |=> $stable({addressBusHigh, addressBusLow}))
        else $error("Address changed during a stalled read");

    // A fetch is always a read
    noSyncWrite: assert property (@(posedge clk) disable iff (!arstN)
        !(sync && !readNotWrite))
        else $error("Sync raised on a write cycle");

endmodule

bind cpuCore cpuCoreProps props_i (.*);

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/100ps

module cpuCoreTb;

    logic         clk;
    logic         arstN;
    logic         ready;
    cpuPkg::byteT dataBusInput;
    cpuPkg::byteT dataBusOutput;
    cpuPkg::byteT addressBusHigh;
    cpuPkg::byteT addressBusLow;
    logic         sync;
    logic         readNotWrite;

    cpuPkg::byteT mem [0:65535];
    cpuPkg::byteT refMem [0:65535];
    cpuPkg::addrT expWriteAddr[$];
    cpuPkg::byteT expWriteData[$];
    cpuPkg::addrT pcTrace[$];
    cpuPkg::addrT loopAddr;
    cpuPkg::addrT busAddr;
    int           errorCount = 0;
    int           refCycles = 0;
    int           cycleCount = 0;
    int           cycleLimit = 1000000;
    int           readsSeen = 0;
    int           loopHits = 0;
    logic         runDone = 1'b0;

    cpuCore dut_i (.*);

    assign busAddr      = {addressBusHigh, addressBusLow};
    assign dataBusInput = mem[busAddr];  // Memory answers in the same cycle

    // Instruction level model of the program that yields the expected writes and fetch addresses
    function automatic void refRun();
        cpuPkg::addrT pc;
        cpuPkg::addrT ea;
        cpuPkg::byteT a;
        cpuPkg::byteT op;
        cpuPkg::byteT b;
        logic [8:0]   s;
        logic         z;
        logic         c;
        logic         taken;
        logic         done;
        pc = {refMem[16'hFFFD], refMem[16'hFFFC]};
        a = 8'h00;
        z = 1'b0;
        c = 1'b0;
        done = 1'b0;
        refCycles = 2;
        for (int steps = 0; steps < 1000 && !done; steps++) begin
            pcTrace.push_back(pc);
            op = refMem[pc];
            b = refMem[cpuPkg::addrT'(pc + 16'd1)];
            ea = {refMem[cpuPkg::addrT'(pc + 16'd2)], b};
            case (op)
                8'hA9: begin
                    a = b;
                    z = (a == 8'h00);
                    pc = pc + 16'd2;
                    refCycles += 2;
                end
                8'hAD: begin
                    a = refMem[ea];
                    z = (a == 8'h00);
                    pc = pc + 16'd3;
                    refCycles += 4;
                end
                8'h8D: begin
                    refMem[ea] = a;
                    expWriteAddr.push_back(ea);
                    expWriteData.push_back(a);
                    pc = pc + 16'd3;
                    refCycles += 4;
                end
                8'h69: begin
                    s = {1'b0, a} + {1'b0, b} + {8'b0, c};
                    a = s[7:0];
                    c = s[8];
                    z = (a == 8'h00);
                    pc = pc + 16'd2;
                    refCycles += 2;
                end
                8'h29: begin
                    a = a & b;
                    z = (a == 8'h00);
                    pc = pc + 16'd2;
                    refCycles += 2;
                end
                8'h4C: begin
                    done = (ea == pc);
                    pc = ea;
                    refCycles += 3;
                end
                8'hF0, 8'hD0: begin
                    taken = (op == 8'hF0) ? z : !z;
                    pc = pc + 16'd2;
                    if (taken) pc = pc + {{8{b[7]}}, b};
                    refCycles += taken ? 3 : 2;
                end
                default: begin
                    pc = pc + 16'd1;  // Any other byte acts as NOP
                    refCycles += 2;
                end
            endcase
        end
    endfunction

    task automatic finishRun();
        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cpuPkg::byteT prog [$] = '{
            8'hA9, 8'h5A, 8'h8D, 8'h00, 8'h03, 8'hAD, 8'h10, 8'h03, 8'h8D, 8'h01, 8'h03,
            8'h69, 8'h70, 8'h8D, 8'h02, 8'h03, 8'h69, 8'h01, 8'h8D, 8'h03, 8'h03,
            8'h29, 8'h0F, 8'h8D, 8'h04, 8'h03, 8'hEA, 8'h29, 8'h00, 8'hF0, 8'h03,
            8'h8D, 8'h05, 8'h03, 8'hD0, 8'h03, 8'h8D, 8'h06, 8'h03, 8'hA9, 8'h03,
            8'h8D, 8'h07, 8'h03, 8'hF0, 8'h05, 8'h4C, 8'h40, 8'h02};
        cpuPkg::byteT loop [$] = '{
            8'h8D, 8'h08, 8'h03, 8'h69, 8'hFE, 8'hD0, 8'hF9, 8'h8D, 8'h09, 8'h03,
            8'h4C, 8'h4A, 8'h02};
        void'($urandom(32'h250d_0e7d));
        arstN = 1'b0;
        ready = 1'b0;
        for (int i = 0; i < 65536; i++) mem[i] = cpuPkg::byteT'(i ^ (i >> 8) ^ 8'h5C);
        foreach (prog[i]) mem[16'h0200 + i] = prog[i];
        foreach (loop[i]) mem[16'h0240 + i] = loop[i];  // Backward BNE loop and final self-loop
        mem[16'h0310] = 8'hC3;
        mem[16'hFFFC] = 8'h00;
        mem[16'hFFFD] = 8'h02;
        for (int i = 0; i < 65536; i++) refMem[i] = mem[i];
        refRun();
        loopAddr = pcTrace[$];
        refCycles += 6;  // Two extra passes through the self-loop
        cycleLimit = 4 * (refCycles * 10 / 7 + 1) + 200 + 8;
        repeat (8) @(posedge clk);
        @(negedge clk) arstN = 1'b1;
        wait (runDone);
        if (expWriteAddr.size() != 0) begin
            $display("Run ended with %0d expected writes never seen", expWriteAddr.size());
            errorCount++;
        end
        finishRun();
    end

    always @(negedge clk) begin
        if (arstN) ready = ($urandom % 10) >= 3;  // Low about 30 percent of cycles
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles without reaching the final loop", cycleCount);
            errorCount++;
            finishRun();
        end
    end

    always @(posedge clk) begin
        if (arstN && !readNotWrite) mem[busAddr] <= dataBusOutput;
    end

    // Compares each completed bus cycle with the model
    always @(posedge clk) begin
        if (arstN && !runDone) begin
            if (!readNotWrite) begin
                if (expWriteAddr.size() == 0) begin
                    $display("Unexpected write of %h to address %h", dataBusOutput, busAddr);
                    errorCount++;
                end else begin
                    if (busAddr != expWriteAddr[0]) begin
                        $display("Mismatch busAddr on write: expected %h, got %h",
                                 expWriteAddr[0], busAddr);
                        errorCount++;
                    end
                    if (dataBusOutput != expWriteData[0]) begin
                        $display("Mismatch dataBusOutput: expected %h, got %h",
                                 expWriteData[0], dataBusOutput);
                        errorCount++;
                    end
                    void'(expWriteAddr.pop_front());
                    void'(expWriteData.pop_front());
                end
            end else if (ready) begin
                if (readsSeen < 2) begin
                    if (busAddr != cpuPkg::addrT'(16'hFFFC + readsSeen)) begin
                        $display("Mismatch busAddr on vector read: expected %h, got %h",
                                 cpuPkg::addrT'(16'hFFFC + readsSeen), busAddr);
                        errorCount++;
                    end
                    readsSeen++;
                end
                if (sync) begin
                    if (pcTrace.size() != 0) begin
                        if (busAddr != pcTrace[0]) begin
                            $display("Mismatch busAddr on sync: expected %h, got %h",
                                     pcTrace[0], busAddr);
                            errorCount++;
                        end
                        void'(pcTrace.pop_front());
                    end else begin
                        if (busAddr != loopAddr) begin
                            $display("Mismatch busAddr in final loop: expected %h, got %h",
                                     loopAddr, busAddr);
                            errorCount++;
                        end
                        loopHits++;
                        if (loopHits == 2) runDone = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== verilog.f ====
logic/cpuPkg.sv
logic/controlBus.sv
logic/instructionLoader.sv
logic/opcodeDecoder.sv
logic/cycleController.sv
logic/internalDataflow.sv
logic/cpuCore.sv
verif/cpuCore_props.sv
verif/cpuCoreTb.sv

// ==== Makefile ====
# Verilator build of the CPU core testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal \
		--top-module cpuCoreTb -f verilog.f --Mdir $(OBJ_DIR) -o cpuCoreSim

run: compile
	./$(OBJ_DIR)/cpuCoreSim > run.log 2>&1; cat run.log
	grep -q "Test completed successfully" run.log

clean:
	rm -rf $(OBJ_DIR) run.log
